/* common/conv_config.svh */
`ifndef CONV_CONFIG_SVH
`define CONV_CONFIG_SVH

// ##################################################
// Image geometry.
// ##################################################

// Pixels per row.
`define IMG_WIDTH 12

// Rows per frame.
`define IMG_HEIGHT 10

// ##################################################
// Kernel and pipeline.
// ##################################################

`define KSIZE 5 // Kernel side. The datapath types assume 5.

// Enabled cycles from an accepted window to its result leaving mac_tree.
`define MAC_LAT 3

`endif

/* common/conv_pkg.sv */
`default_nettype none

package conv_pkg;

  // Raw stream samples.
  typedef logic [5:0] pixel_t;
  typedef logic [5:0] coef_t;

  // One tap product. 63 * 63 fits in 12 bits.
  typedef logic [11:0] prod_t;

  // Full window result wide enough for 25 maximum products.
  typedef logic [17:0] sum_t;

  // Vertical slice of the window. Index 0 is the oldest (top) row.
  typedef pixel_t [4:0] column_t;

  // 25 taps at index 5*r + c.
  // Row 0 on top, column 0 on the left.
  typedef pixel_t [24:0] window_t;

  // Coefficients, indexed like the window.
  typedef coef_t [24:0] kernel_t;

endpackage

`default_nettype wire

/* common/conv_ctrl_pkg.sv */
`default_nettype none

package conv_ctrl_pkg;

  // Coefficient load, then frame run.
  typedef enum logic {
    LOAD = 1'b0,
    RUN  = 1'b1
  } ctrl_state_t;

  // Position of the accepted pixel inside the frame.
  typedef logic [7:0] col_cnt_t;
  typedef logic [7:0] row_cnt_t;

  typedef logic [4:0] coef_idx_t; // 0 to 24.

endpackage

`default_nettype wire

/* design/skid_buffer.sv */
`default_nettype none

module skid_buffer import conv_pkg::*; #(
  parameter type payload_t = pixel_t
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  logic     main_valid;
  logic     skid_valid;
  payload_t main_data;
  payload_t skid_data;
  logic     push;
  logic     pop;

  assign push      = in_valid & in_ready;
  assign pop       = main_valid & out_ready;
  assign out_valid = main_valid;
  assign out_data  = main_data;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
      in_ready   <= 1'b0;
    end else if (!main_valid || pop) begin
      main_valid <= skid_valid | push; // Skid entry drains first.
      skid_valid <= 1'b0;
      in_ready   <= 1'b1;
    end else if (push) begin
      skid_valid <= 1'b1; // Both entries full.
      in_ready   <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (!main_valid || pop) begin
      main_data <= skid_valid ? skid_data : in_data;
    end
    if (main_valid && !pop && push) begin
      skid_data <= in_data;
    end
  end

endmodule

`default_nettype wire

/* conv_core/conv_ctrl.sv */
`default_nettype none
`include "conv_config.svh"

module conv_ctrl import conv_pkg::*, conv_ctrl_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      coef_valid,
  input  logic      pix_avail,
  input  logic      out_space,
  input  logic      pipe_busy,
  output logic      coef_ready,
  output logic      coef_we,
  output coef_idx_t coef_idx,
  output logic      advance,
  output logic      win_valid,
  output logic      win_last
);

  localparam col_cnt_t  LAST_COL      = col_cnt_t'(`IMG_WIDTH - 1);
  localparam row_cnt_t  LAST_ROW      = row_cnt_t'(`IMG_HEIGHT - 1);
  localparam col_cnt_t  FIRST_WIN_COL = col_cnt_t'(`KSIZE - 1);
  localparam row_cnt_t  FIRST_WIN_ROW = row_cnt_t'(`KSIZE - 1);
  localparam coef_idx_t LAST_COEF     = coef_idx_t'(`KSIZE * `KSIZE - 1);

  ctrl_state_t state;
  col_cnt_t    col_cnt;
  row_cnt_t    row_cnt;
  logic        run;
  logic        end_of_row;
  logic        end_of_frame;

  assign run     = (state == RUN);
  assign coef_we = coef_valid & coef_ready;

  // ##################################################
  // Data movement.
  // ##################################################

  // In LOAD the pipe drains only while no pixel is waiting.
  // Drain shifts also step the line buffer pointer.
  // Every slot still sees vertically aligned pixels.
  assign advance = out_space & (run ? pix_avail : ((pipe_busy | win_valid) & ~pix_avail));

  assign end_of_row   = (col_cnt == LAST_COL);
  assign end_of_frame = end_of_row & (row_cnt == LAST_ROW);

  // Flags for the window now held in window_regs.
  // Only fully covered windows count.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      win_valid <= 1'b0;
      win_last  <= 1'b0;
    end else if (advance) begin
      win_valid <= run & (row_cnt >= FIRST_WIN_ROW) & (col_cnt >= FIRST_WIN_COL);
      win_last  <= run & end_of_frame;
    end
  end

  // ##################################################
  // State and counters.
  // ##################################################

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= LOAD;
      coef_ready <= 1'b0;
      coef_idx   <= '0;
      col_cnt    <= '0;
      row_cnt    <= '0;
    end else begin
      case (state)
        LOAD: begin
          coef_ready <= 1'b1;
          if (coef_we) begin
            if (coef_idx == LAST_COEF) begin
              coef_idx   <= '0;
              coef_ready <= 1'b0; // Kernel complete.
              state      <= RUN;
            end else begin
              coef_idx <= coef_idx + 1'b1;
            end
          end
        end
        RUN: begin
          if (advance) begin
            if (end_of_row) begin
              col_cnt <= '0;
              row_cnt <= end_of_frame ? '0 : row_cnt + 1'b1;
            end else begin
              col_cnt <= col_cnt + 1'b1;
            end
            if (end_of_frame) begin
              state      <= LOAD;
              coef_ready <= 1'b1;
            end
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* conv_core/line_buffer.sv */
`default_nettype none
`include "conv_config.svh"

module line_buffer import conv_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    shift,
  input  pixel_t  pix_in,
  output column_t column
);

  localparam int unsigned NROWS = `KSIZE - 1;
  localparam int unsigned PTR_W = $clog2(`IMG_WIDTH);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(`IMG_WIDTH - 1);

  // Row 0 holds the oldest line.
  pixel_t row_mem [NROWS][`IMG_WIDTH];

  logic [PTR_W-1:0] ptr;

  // ##################################################
  // Column read.
  // ##################################################

  always_comb begin
    for (int r = 0; r < NROWS; r++) begin
      column[r] = row_mem[r][ptr];
    end
    column[NROWS] = pix_in; // Newest row at the bottom.
  end

  // ##################################################
  // Roll memories upward.
  // ##################################################

  always_ff @(posedge clk) begin
    if (shift) begin
      for (int r = 0; r < NROWS - 1; r++) begin
        row_mem[r][ptr] <= row_mem[r + 1][ptr];
      end
      row_mem[NROWS - 1][ptr] <= pix_in;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ptr <= '0;
    end else if (shift) begin
      ptr <= (ptr == LAST_PTR) ? '0 : ptr + 1'b1; // Wraps once per row.
    end
  end

endmodule

`default_nettype wire

/* conv_core/window_regs.sv */
`default_nettype none

module window_regs import conv_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    shift,
  input  column_t column,
  output window_t window
);

  localparam int unsigned SIDE = 5;

  // ##################################################
  // 5x5 tap shift register.
  // ##################################################

  // Taps move left and the new column enters on the right.
  // Windows that wrap across a row edge get formed too;
  // conv_ctrl marks those invalid.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      window <= '0;
    end else if (shift) begin
      for (int r = 0; r < SIDE; r++) begin
        for (int c = 0; c < SIDE - 1; c++) begin
          window[SIDE * r + c] <= window[SIDE * r + c + 1];
        end
        window[SIDE * r + SIDE - 1] <= column[r]; // Rightmost tap.
      end
    end
  end

endmodule

`default_nettype wire

/* conv_core/mac_tree.sv */
`default_nettype none
`include "conv_config.svh"

module mac_tree import conv_pkg::*, conv_ctrl_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      en,
  input  logic      coef_we,
  input  coef_idx_t coef_idx,
  input  coef_t     coef_in,
  input  window_t   window,
  input  logic      win_valid,
  input  logic      win_last,
  output sum_t      sum,
  output logic      sum_valid,
  output logic      sum_last,
  output logic      pipe_busy
);

  localparam int unsigned NTAPS = `KSIZE * `KSIZE;
  localparam int unsigned NLVL1 = NTAPS / 2;     // Pairs with the last tap carried.
  localparam int unsigned NPART = NLVL1 / 2 + 1; // 25 -> 13 -> 7.

  kernel_t kernel;
  prod_t   prod [NTAPS];
  sum_t    lvl1 [NLVL1];
  sum_t    part [NPART];
  sum_t    tree_total;

  logic [`MAC_LAT-1:0] vld_pipe;
  logic [`MAC_LAT-1:0] last_pipe;

  always_ff @(posedge clk) begin
    if (coef_we) begin
      kernel[coef_idx] <= coef_in;
    end
  end

  // ##################################################
  // Adder tree.
  // ##################################################

  always_comb begin
    for (int j = 0; j < NLVL1; j++) begin
      lvl1[j] = sum_t'(prod[2 * j]) + sum_t'(prod[2 * j + 1]);
    end
  end

  always_comb begin
    tree_total = '0;
    for (int i = 0; i < NPART; i++) begin
      tree_total = tree_total + part[i];
    end
  end

  // Three registered stages. All of them hold while en is low.
  always_ff @(posedge clk) begin
    if (en) begin
      for (int i = 0; i < NTAPS; i++) begin
        prod[i] <= window[i] * kernel[i];
      end
      for (int i = 0; i < NPART - 1; i++) begin
        part[i] <= lvl1[2 * i] + lvl1[2 * i + 1];
      end
      part[NPART - 1] <= sum_t'(prod[NTAPS - 1]); // Odd tap rides along.
      sum <= tree_total;
    end
  end

  // ##################################################
  // Sideband bits.
  // ##################################################

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vld_pipe  <= '0;
      last_pipe <= '0;
    end else if (en) begin
      vld_pipe  <= {vld_pipe[`MAC_LAT-2:0], win_valid};
      last_pipe <= {last_pipe[`MAC_LAT-2:0], win_last};
    end
  end

  assign sum_valid = vld_pipe[`MAC_LAT-1];
  assign sum_last  = last_pipe[`MAC_LAT-1];
  assign pipe_busy = |vld_pipe;

endmodule

`default_nettype wire

/* design/conv_top.sv */
`default_nettype none

module conv_top import conv_pkg::*, conv_ctrl_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   coef_valid,
  output logic   coef_ready,
  input  coef_t  coef_data,
  input  logic   pix_valid,
  output logic   pix_ready,
  input  pixel_t pix_data,
  output logic   res_valid,
  input  logic   res_ready,
  output sum_t   res_data,
  output logic   res_last
);

  // Result word with its frame marker.
  typedef struct packed {
    logic last;
    sum_t sum;
  } res_item_t;

  pixel_t    pix_q;
  logic      pix_avail;
  logic      advance;
  logic      coef_we;
  coef_idx_t coef_idx;
  column_t   column;
  window_t   window;
  logic      win_valid;
  logic      win_last;
  sum_t      sum;
  logic      sum_valid;
  logic      sum_last;
  logic      pipe_busy;
  logic      res_space;
  res_item_t res_in;
  res_item_t res_q;

  // ##################################################
  // Input side.
  // ##################################################

  skid_buffer #(.payload_t(pixel_t)) u_pix_buf (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (pix_valid),
    .in_ready (pix_ready),
    .in_data  (pix_data),
    .out_valid(pix_avail),
    .out_ready(advance),
    .out_data (pix_q)
  );

  conv_ctrl u_conv_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .coef_valid(coef_valid),
    .pix_avail (pix_avail),
    .out_space (res_space),
    .pipe_busy (pipe_busy),
    .coef_ready(coef_ready),
    .coef_we   (coef_we),
    .coef_idx  (coef_idx),
    .advance   (advance),
    .win_valid (win_valid),
    .win_last  (win_last)
  );

  // ##################################################
  // Datapath.
  // ##################################################

  line_buffer u_line_buffer (
    .clk   (clk),
    .rst_n (rst_n),
    .shift (advance),
    .pix_in(pix_q),
    .column(column)
  );

  window_regs u_window_regs (
    .clk   (clk),
    .rst_n (rst_n),
    .shift (advance),
    .column(column),
    .window(window)
  );

  mac_tree u_mac_tree (
    .clk      (clk),
    .rst_n    (rst_n),
    .en       (advance),
    .coef_we  (coef_we),
    .coef_idx (coef_idx),
    .coef_in  (coef_data),
    .window   (window),
    .win_valid(win_valid),
    .win_last (win_last),
    .sum      (sum),
    .sum_valid(sum_valid),
    .sum_last (sum_last),
    .pipe_busy(pipe_busy)
  );

  // ##################################################
  // Output side.
  // ##################################################

  assign res_in.last = sum_last;
  assign res_in.sum  = sum;

  // An item is written as it leaves the last stage.
  skid_buffer #(.payload_t(res_item_t)) u_res_buf (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (advance & sum_valid),
    .in_ready (res_space),
    .in_data  (res_in),
    .out_valid(res_valid),
    .out_ready(res_ready),
    .out_data (res_q)
  );

  assign res_data = res_q.sum;
  assign res_last = res_valid & res_q.last; // Low while the buffer is empty.

endmodule

`default_nettype wire

/* dv/conv_ref_model.svh */
`ifndef CONV_REF_MODEL_SVH
`define CONV_REF_MODEL_SVH

// Golden model of the "valid" 5x5 convolution. Results come in raster order.

localparam int OUT_W = `IMG_WIDTH - `KSIZE + 1;
localparam int OUT_H = `IMG_HEIGHT - `KSIZE + 1;

// Frame in raster order at index row * IMG_WIDTH + col.
typedef pixel_t image_t [`IMG_WIDTH * `IMG_HEIGHT];

function automatic int result_count();
  return OUT_W * OUT_H;
endfunction

// Result n covers rows n / OUT_W to +4 and columns n % OUT_W to +4.
function automatic sum_t window_sum(input image_t img, input kernel_t kern, input int n);
  int   top;
  int   left;
  sum_t pix;
  sum_t coef;
  sum_t acc;
  top  = n / OUT_W;
  left = n % OUT_W;
  acc  = '0;
  for (int r = 0; r < `KSIZE; r++) begin
    for (int c = 0; c < `KSIZE; c++) begin
      pix  = sum_t'(img[(top + r) * `IMG_WIDTH + left + c]);
      coef = sum_t'(kern[`KSIZE * r + c]); // Same 5*r + c indexing as the window.
      acc  = acc + pix * coef;
    end
  end
  return acc;
endfunction

function automatic bit is_final_result(input int n);
  return n == result_count() - 1;
endfunction

`endif

/* dv/tb_conv_top.sv */
`default_nettype none
`include "conv_config.svh"

module tb_conv_top import conv_pkg::*; ();

`include "conv_ref_model.svh"

  localparam int NTAPS         = `KSIZE * `KSIZE;
  localparam int NPIX          = `IMG_WIDTH * `IMG_HEIGHT;
  localparam int NUM_TESTS     = 6;
  localparam int CLK_PERIOD    = 20;
  localparam int FRAME_CYCLES  = (NTAPS + NPIX) * 4;
  localparam int SETTLE_CYCLES = 4 * `MAC_LAT + 4;
  localparam longint WATCHDOG_LIMIT =
    longint'(NUM_TESTS) * FRAME_CYCLES * CLK_PERIOD + 200 * CLK_PERIOD;

  // Kernel pattern codes.
  localparam int KER_IDENT = 0;
  localparam int KER_ONES  = 1;
  localparam int KER_MAX   = 2;
  localparam int KER_RAND  = 3;
  localparam int KER_SAME  = 4;

  // Image pattern codes.
  localparam int IMG_RAMP  = 0;
  localparam int IMG_MAX   = 1;
  localparam int IMG_RAND  = 2;
  localparam int IMG_SAME  = 3;

  typedef struct {
    string name;
    int    kern;
    int    img;
    bit    stall;     // Random res_ready.
    bit    has_fixed;
    sum_t  fixed_sum; // Known value of every result.
  } test_row_t;

  logic   clk;
  logic   rst_n;
  logic   coef_valid;
  logic   coef_ready;
  coef_t  coef_data;
  logic   pix_valid;
  logic   pix_ready;
  pixel_t pix_data;
  logic   res_valid;
  logic   res_ready;
  sum_t   res_data;
  logic   res_last;

  test_row_t tests [NUM_TESTS];
  kernel_t   cur_kernel;
  image_t    cur_image;
  sum_t      got_sum [$];
  bit        got_last [$];
  int        seed = 32'h1db232af;
  bit        stall_en;
  int        error_count;
  int        check_count;
  int        test_errors;
  int        pass_count;

  conv_top u_conv_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .coef_valid(coef_valid),
    .coef_ready(coef_ready),
    .coef_data (coef_data),
    .pix_valid (pix_valid),
    .pix_ready (pix_ready),
    .pix_data  (pix_data),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .res_data  (res_data),
    .res_last  (res_last)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ##################################################
  // Test table.
  // ##################################################

  task automatic fill_table();
    tests[0] = '{"identity_ramp", KER_IDENT, IMG_RAMP, 1'b0, 1'b0, sum_t'(0)};
    tests[1] = '{"ones_random", KER_ONES, IMG_RAND, 1'b0, 1'b0, sum_t'(0)};
    tests[2] = '{"max_constant", KER_MAX, IMG_MAX, 1'b0, 1'b1, sum_t'(99225)};
    tests[3] = '{"random_random", KER_RAND, IMG_RAND, 1'b0, 1'b0, sum_t'(0)};
    tests[4] = '{"random_stalled", KER_SAME, IMG_SAME, 1'b1, 1'b0, sum_t'(0)}; // Repeat of 3.
    tests[5] = '{"ones_ramp_stalled", KER_ONES, IMG_RAMP, 1'b1, 1'b0, sum_t'(0)};
  endtask

  task automatic build_kernel(input int code);
    for (int i = 0; i < NTAPS; i++) begin
      case (code)
        KER_IDENT: cur_kernel[i] = (i == NTAPS / 2) ? coef_t'(1) : coef_t'(0);
        KER_ONES:  cur_kernel[i] = coef_t'(1);
        KER_MAX:   cur_kernel[i] = coef_t'(63);
        KER_RAND:  cur_kernel[i] = coef_t'($random(seed));
        default:   cur_kernel[i] = cur_kernel[i];
      endcase
    end
  endtask

  task automatic build_image(input int code);
    for (int i = 0; i < NPIX; i++) begin
      case (code)
        IMG_RAMP: cur_image[i] = pixel_t'(i);
        IMG_MAX:  cur_image[i] = pixel_t'(63);
        IMG_RAND: cur_image[i] = pixel_t'($random(seed));
        default:  cur_image[i] = cur_image[i];
      endcase
    end
  endtask

  // ##################################################
  // Stimulus and checks.
  // ##################################################

  task automatic check_reset_outputs();
    check_count++;
    if (coef_ready !== 1'b0 || pix_ready !== 1'b0 ||
        res_valid !== 1'b0 || res_last !== 1'b0) begin
      $display("Reset: a ready, valid or last output is not low during reset");
      error_count++;
    end
  endtask

  task automatic send_kernel(input string name);
    int  sent;
    bit  taken;
    sent = 0;
    @(posedge clk);
    coef_valid <= 1'b1;
    coef_data  <= cur_kernel[0];
    while (sent < NTAPS) begin
      @(negedge clk);
      taken = coef_valid && coef_ready;
      @(posedge clk);
      if (taken) begin
        sent++;
        if (sent < NTAPS) begin
          coef_data <= cur_kernel[sent];
        end else begin
          coef_valid <= 1'b0;
        end
      end
    end
    @(negedge clk);
    if (coef_ready) begin
      $display("Test %s: coef_ready still high after %0d coefficients", name, NTAPS);
      error_count++;
      test_errors++;
    end
  endtask

  task automatic send_frame();
    int sent;
    bit taken;
    sent = 0;
    @(posedge clk);
    pix_valid <= 1'b1;
    pix_data  <= cur_image[0];
    while (sent < NPIX) begin
      @(negedge clk);
      taken = pix_valid && pix_ready;
      @(posedge clk);
      if (taken) begin
        sent++;
        if (sent < NPIX) begin
          pix_data <= cur_image[sent];
        end else begin
          pix_valid <= 1'b0;
        end
      end
    end
  endtask

  task automatic check_sum(input string name, input int n, input sum_t expected,
                           input sum_t actual);
    check_count++;
    if (expected !== actual) begin
      $display("ERR %s result %0d: expected %0d, actual %0d", name, n, expected, actual);
      error_count++;
      test_errors++;
    end
  endtask

  task automatic check_last(input string name, input int n, input bit expected,
                            input bit actual);
    check_count++;
    if (expected !== actual) begin
      $display("ERR %s last flag of result %0d: expected %0b, actual %0b",
               name, n, expected, actual);
      error_count++;
      test_errors++;
    end
  endtask

  task automatic run_test(input int t);
    int nres;
    int waited;
    test_errors = 0;
    nres = result_count();
    build_kernel(tests[t].kern);
    build_image(tests[t].img);
    stall_en = tests[t].stall;
    got_sum.delete();
    got_last.delete();
    send_kernel(tests[t].name);
    send_frame();
    waited = 0;
    while (got_sum.size() < nres && waited < FRAME_CYCLES) begin
      @(negedge clk);
      waited++;
    end
    repeat (SETTLE_CYCLES) @(negedge clk); // Room for stray extra results.
    if (got_sum.size() != nres) begin
      $display("Test %s: expected %0d results but received %0d",
               tests[t].name, nres, got_sum.size());
      error_count++;
      test_errors++;
    end
    for (int n = 0; n < nres && n < got_sum.size(); n++) begin
      check_sum(tests[t].name, n, window_sum(cur_image, cur_kernel, n), got_sum[n]);
      if (tests[t].has_fixed) begin
        check_sum(tests[t].name, n, tests[t].fixed_sum, got_sum[n]);
      end
      check_last(tests[t].name, n, is_final_result(n), got_last[n]);
    end
    if (test_errors == 0) begin
      pass_count++;
      $display("Test %s: pass", tests[t].name);
    end else begin
      $display("Test %s: fail with %0d errors", tests[t].name, test_errors);
    end
  endtask

  // ##################################################
  // Processes.
  // ##################################################

  initial begin
    int rnd;
    forever begin
      @(posedge clk);
      if (stall_en) begin
        rnd = $random(seed);
        res_ready <= rnd[0];
      end else begin
        res_ready <= 1'b1;
      end
    end
  end

  // Transfer happens on the next rising edge.
  initial begin
    forever begin
      @(negedge clk);
      if (rst_n && res_valid && res_ready) begin
        got_sum.push_back(res_data);
        got_last.push_back(res_last);
      end
    end
  end

  initial begin
    #(WATCHDOG_LIMIT);
    $display("Timeout: run did not finish within %0d time units", WATCHDOG_LIMIT);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    rst_n       = 1'b0;
    coef_valid  = 1'b0;
    coef_data   = '0;
    pix_valid   = 1'b0;
    pix_data    = '0;
    res_ready   = 1'b0;
    stall_en    = 1'b0;
    error_count = 0;
    check_count = 0;
    pass_count  = 0;
    fill_table();
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_reset_outputs();
    @(posedge clk);
    rst_n <= 1'b1;
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    $display("Summary: %0d tests, %0d passed, %0d failed, %0d checks, %0d errors",
             NUM_TESTS, pass_count, NUM_TESTS - pass_count, check_count, error_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+common
+incdir+dv
common/conv_pkg.sv
common/conv_ctrl_pkg.sv
design/skid_buffer.sv
conv_core/conv_ctrl.sv
conv_core/line_buffer.sv
conv_core/window_regs.sv
conv_core/mac_tree.sv
design/conv_top.sv
dv/tb_conv_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the convolution testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -j 0 \
  --top-module tb_conv_top -f vlog.f -o tb_conv_top

./obj_dir/tb_conv_top > sim.log 2>&1
cat sim.log

if grep -q "Finished with errors" sim.log; then
  echo "Simulation failed, see sim.log"
  exit 1
fi

echo "Simulation passed"
